/* hdl/kl10WordPkg.sv */
package kl10WordPkg;

  // Bit 35 is the least significant bit, so PDP-10 bit n sits at index 35-n
  typedef logic [35:0] kl10Word;

  typedef logic [4:0] sectionT;

  typedef logic [17:0] offsetT;

  // Right-justified like PDP-10 bits 12..35 of a word
  typedef struct packed {
    logic    misc;
    sectionT section;
    offsetT  offset;
  } vmaAddrT;

  typedef logic [8:0] magicT;

  // Offsets below this reference the fast accumulators
  localparam offsetT acLimit = 18'd16;

endpackage

/* hdl/vmaCtlPkg.sv */
package vmaCtlPkg;

  import kl10WordPkg::*;

  // VMAX section source
  typedef enum logic [1:0] {
    keepSec = 2'd0,
    pcSec   = 2'd1,
    prevSec = 2'd2,
    adSec   = 2'd3
  } vmaxSelT;

  typedef enum logic [2:0] {
    diagVma   = 3'd0,
    diagPc    = 3'd1,
    diagHeld  = 3'd2,
    diagBrk   = 3'd3,
    diagFlags = 3'd4
  } diagSelT;

  // Microcode and condition strobes for one cycle
  typedef struct packed {
    logic    loadVma;
    logic    vmaAd;
    logic    vmaInc;
    logic    magicEn;
    magicT   magic;
    logic    vmaxEn;
    vmaxSelT vmaxSel;
    logic    loadPc;
    logic    loadHeld;
    logic    dataoApr;
    logic    loadPrevContext;
    logic    condSelVma;
    logic    extended;
    logic    fetch;
    logic    memRef;
    logic    diagRead;
    diagSelT diagSel;
  } vmaCtlT;

  typedef struct packed {
    logic acRef;
    // Local addressing in effect
    logic localAddr;
    logic localAc;
    logic vmaSec0;
    logic pcSec0;
    logic prevSec0;
    logic match;
  } vmaFlagsT;

endpackage

/* hdl/vmaDatapath.sv */
`timescale 1ns/100ps

module vmaDatapath import kl10WordPkg::*, vmaCtlPkg::*; (
  input  logic    clk,
  input  logic    reset,
  input  vmaCtlT  ctl,
  input  kl10Word ad,
  input  offsetT  trapMix,
  input  sectionT prevSection,
  output vmaAddrT vma,
  output vmaAddrT pc,
  output vmaAddrT held,
  output vmaAddrT heldOrPc
);

  offsetT  adderBase;
  offsetT  adderMagic;
  offsetT  adderInc;
  offsetT  adderSum;
  offsetT  nextOffset;
  sectionT vmaxSection;
  sectionT nextSection;
  logic    nextMisc;
  logic    trapSel;

  // Magic of zero with an increment picks up the trap vector
  assign trapSel = ctl.magicEn & ctl.vmaInc & (ctl.magic == '0);

  always_comb begin
    adderBase  = trapSel ? trapMix : pc.offset;
    adderMagic = ctl.magicEn ? offsetT'(ctl.magic) : '0;
    adderInc   = offsetT'(ctl.vmaInc);
    adderSum   = adderBase + adderMagic + adderInc;
  end

  // VMAX select
  always_comb begin
    case (ctl.vmaxSel)
      keepSec: vmaxSection = vma.section;
      pcSec:   vmaxSection = pc.section;
      prevSec: vmaxSection = prevSection;
      adSec:   vmaxSection = ad[22:18];
    endcase
  end

  always_comb begin
    nextOffset  = vma.offset;
    nextSection = vma.section;
    nextMisc    = vma.misc;
    if (ctl.loadVma) begin
      if (ctl.vmaAd) begin
        nextOffset = ad[17:0];
        // PDP-10 bit 12
        nextMisc   = ad[23];
      end else begin
        nextOffset = adderSum;
      end
      if (ctl.vmaxEn) begin
        nextSection = vmaxSection;
      end
    end else if (ctl.vmaInc) begin
      nextOffset = vma.offset + 18'd1;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      vma <= '0;
    end else begin
      vma.misc    <= nextMisc;
      vma.section <= nextSection;
      vma.offset  <= nextOffset;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= '0;
    end else if (ctl.loadPc) begin
      pc <= vma;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      held <= '0;
    end else if (ctl.loadHeld) begin
      held <= vma;
    end
  end

  assign heldOrPc = ctl.condSelVma ? held : pc;

endmodule

/* hdl/vmaConfigRegs.sv */
`timescale 1ns/100ps

module vmaConfigRegs import kl10WordPkg::*, vmaCtlPkg::*; (
  input  logic    clk,
  input  logic    reset,
  input  vmaCtlT  ctl,
  input  kl10Word ad,
  output vmaAddrT adrBrk,
  output sectionT prevSection
);

  // Address break loads right-justified on DATAO APR
  always_ff @(posedge clk) begin
    if (reset) begin
      adrBrk <= '0;
    end else if (ctl.dataoApr) begin
      adrBrk <= vmaAddrT'(ad[23:0]);
    end
  end

  // Previous context section from PDP-10 bits 13..17
  always_ff @(posedge clk) begin
    if (reset) begin
      prevSection <= '0;
    end else if (ctl.loadPrevContext) begin
      prevSection <= ad[22:18];
    end
  end

endmodule

/* hdl/vmaDecode.sv */
`timescale 1ns/100ps

module vmaDecode import kl10WordPkg::*, vmaCtlPkg::*; (
  input  vmaCtlT   ctl,
  input  vmaAddrT  vma,
  input  vmaAddrT  pc,
  input  vmaAddrT  adrBrk,
  input  sectionT  prevSection,
  output vmaFlagsT flags
);

  logic vmaSec0;
  logic pcSec0;
  logic prevSec0;
  logic isLocal;
  logic acRange;
  logic acRef;

  always_comb begin
    vmaSec0  = vma.section == '0;
    pcSec0   = pc.section == '0;
    prevSec0 = prevSection == '0;
  end

  // Non-extended, instruction fetch, or section zero
  assign isLocal = ~ctl.extended | ctl.fetch | vmaSec0;

  assign acRange = vma.offset < acLimit;
  assign acRef   = ctl.memRef & isLocal & acRange & ~vma.misc;

  always_comb begin
    flags.acRef     = acRef;
    flags.localAddr = isLocal;
    flags.localAc   = acRef & ~vmaSec0;
    flags.vmaSec0   = vmaSec0;
    flags.pcSec0    = pcSec0;
    flags.prevSec0  = prevSec0;
    // Misc bit is not part of the break compare
    flags.match     = (adrBrk.section == vma.section) &&
                      (adrBrk.offset == vma.offset);
  end

endmodule

/* hdl/vmaDiagMux.sv */
`timescale 1ns/100ps

module vmaDiagMux import kl10WordPkg::*, vmaCtlPkg::*; (
  input  vmaCtlT   ctl,
  input  vmaAddrT  vma,
  input  vmaAddrT  pc,
  input  vmaAddrT  held,
  input  vmaAddrT  adrBrk,
  input  sectionT  prevSection,
  input  vmaFlagsT flags,
  output kl10Word  ebusData,
  output logic     ebusDriving
);

  kl10Word diagField;

  // Fields come out right-justified
  always_comb begin
    case (ctl.diagSel)
      diagVma:   diagField = kl10Word'(vma);
      diagPc:    diagField = kl10Word'(pc);
      diagHeld:  diagField = kl10Word'(held);
      diagBrk:   diagField = kl10Word'(adrBrk);
      diagFlags: diagField = kl10Word'({prevSection, flags});
      default:   diagField = '0;
    endcase
  end

  assign ebusDriving = ctl.diagRead;

  // Bus is idle low when not reading
  assign ebusData = ctl.diagRead ? diagField : '0;

endmodule

/* hdl/vmaBoard.sv */
`timescale 1ns/100ps

module vmaBoard import kl10WordPkg::*, vmaCtlPkg::*; (
  input  logic     clk,
  input  logic     reset,
  input  vmaCtlT   ctl,
  input  kl10Word  ad,
  input  offsetT   trapMix,
  output vmaAddrT  vma,
  output vmaAddrT  pc,
  output vmaAddrT  heldOrPc,
  output vmaFlagsT flags,
  output kl10Word  ebusData,
  output logic     ebusDriving
);

  vmaAddrT held;
  vmaAddrT adrBrk;
  sectionT prevSection;

  vmaDatapath datapath (
    .clk         (clk),
    .reset       (reset),
    .ctl         (ctl),
    .ad          (ad),
    .trapMix     (trapMix),
    .prevSection (prevSection),
    .vma         (vma),
    .pc          (pc),
    .held        (held),
    .heldOrPc    (heldOrPc)
  );

  vmaConfigRegs configRegs (
    .clk         (clk),
    .reset       (reset),
    .ctl         (ctl),
    .ad          (ad),
    .adrBrk      (adrBrk),
    .prevSection (prevSection)
  );

  vmaDecode decode (
    .ctl         (ctl),
    .vma         (vma),
    .pc          (pc),
    .adrBrk      (adrBrk),
    .prevSection (prevSection),
    .flags       (flags)
  );

  vmaDiagMux diagMux (
    .ctl         (ctl),
    .vma         (vma),
    .pc          (pc),
    .held        (held),
    .adrBrk      (adrBrk),
    .prevSection (prevSection),
    .flags       (flags),
    .ebusData    (ebusData),
    .ebusDriving (ebusDriving)
  );

endmodule

/* tb/vmaBoard_assertions.sv */
`timescale 1ns/100ps

module vmaBoard_assertions import kl10WordPkg::*, vmaCtlPkg::*; (
  input logic     clk,
  input logic     reset,
  input vmaCtlT   ctl,
  input kl10Word  ad,
  input offsetT   trapMix,
  input vmaAddrT  vma,
  input vmaAddrT  pc,
  input vmaAddrT  held,
  input vmaAddrT  heldOrPc,
  input vmaAddrT  adrBrk,
  input sectionT  prevSection,
  input vmaFlagsT flags,
  input kl10Word  ebusData,
  input logic     ebusDriving
);

  int failCount = 0;

  offsetT      adderBase;
  logic [19:0] adderSum;
  vmaAddrT     nextVma;
  vmaAddrT     expVma;
  vmaAddrT     expPc;
  vmaAddrT     expHeld;
  vmaFlagsT    expFlags;
  kl10Word     expEbus;
  logic        localExp;

  // Trap vector stands in for the PC when magic is zero with increment
  always_comb begin
    if (ctl.magicEn && ctl.vmaInc && ctl.magic == 9'd0) begin
      adderBase = trapMix;
    end else begin
      adderBase = pc.offset;
    end
    adderSum = 20'(adderBase) + 20'(ctl.vmaInc);
    if (ctl.magicEn) begin
      adderSum = adderSum + 20'(ctl.magic);
    end
  end

  always_comb begin
    nextVma = vma;
    if (ctl.loadVma) begin
      nextVma.offset = ctl.vmaAd ? ad[17:0] : adderSum[17:0];
      if (ctl.vmaAd) begin
        nextVma.misc = ad[23];
      end
      if (ctl.vmaxEn) begin
        case (ctl.vmaxSel)
          pcSec:   nextVma.section = pc.section;
          prevSec: nextVma.section = prevSection;
          adSec:   nextVma.section = ad[22:18];
          default: nextVma.section = vma.section;
        endcase
      end
    end else if (ctl.vmaInc) begin
      nextVma.offset = vma.offset + 18'd1;
    end
  end

  always_ff @(posedge clk) begin
    expVma  <= nextVma;
    expPc   <= ctl.loadPc ? vma : pc;
    expHeld <= ctl.loadHeld ? vma : held;
  end

  always_comb begin
    localExp           = !ctl.extended || ctl.fetch || vma.section == 5'd0;
    expFlags.localAddr = localExp;
    expFlags.acRef     = ctl.memRef && localExp && vma.offset < acLimit && !vma.misc;
    expFlags.localAc   = expFlags.acRef && vma.section != 5'd0;
    expFlags.vmaSec0   = vma.section == 5'd0;
    expFlags.pcSec0    = pc.section == 5'd0;
    expFlags.prevSec0  = prevSection == 5'd0;
    expFlags.match     = adrBrk.section == vma.section && adrBrk.offset == vma.offset;
  end

  always_comb begin
    expEbus = '0;
    if (ctl.diagRead) begin
      case (ctl.diagSel)
        diagVma:   expEbus[23:0] = vma;
        diagPc:    expEbus[23:0] = pc;
        diagHeld:  expEbus[23:0] = held;
        diagBrk:   expEbus[23:0] = adrBrk;
        diagFlags: expEbus[11:0] = {prevSection, expFlags};
        default:   expEbus = '0;
      endcase
    end
  end

  vmaUpdate: assert property (@(posedge clk) disable iff (reset)
      !$past(reset) |-> vma == expVma)
    else begin
      failCount++;
      $error("FAIL %0t vma expected %h got %h", $time, $sampled(expVma), $sampled(vma));
    end

  pcUpdate: assert property (@(posedge clk) disable iff (reset)
      !$past(reset) |-> pc == expPc)
    else begin
      failCount++;
      $error("FAIL %0t pc expected %h got %h", $time, $sampled(expPc), $sampled(pc));
    end

  heldUpdate: assert property (@(posedge clk) disable iff (reset)
      !$past(reset) |-> held == expHeld)
    else begin
      failCount++;
      $error("FAIL %0t held expected %h got %h", $time, $sampled(expHeld), $sampled(held));
    end

  heldOrPcSelect: assert property (@(posedge clk) disable iff (reset)
      heldOrPc == (ctl.condSelVma ? held : pc))
    else begin
      failCount++;
      $error("FAIL %0t heldOrPc expected %h got %h", $time,
             $sampled(ctl.condSelVma ? held : pc), $sampled(heldOrPc));
    end

  flagsDecode: assert property (@(posedge clk) disable iff (reset) flags == expFlags)
    else begin
      failCount++;
      $error("FAIL %0t flags expected %b got %b", $time, $sampled(expFlags), $sampled(flags));
    end

  ebusDrive: assert property (@(posedge clk) ebusDriving == ctl.diagRead)
    else begin
      failCount++;
      $error("FAIL %0t ebusDriving expected %b got %b", $time,
             $sampled(ctl.diagRead), $sampled(ebusDriving));
    end

  ebusField: assert property (@(posedge clk) disable iff (reset) ebusData == expEbus)
    else begin
      failCount++;
      $error("FAIL %0t ebusData expected %h got %h", $time, $sampled(expEbus),
             $sampled(ebusData));
    end

  resetState: assert property (@(posedge clk)
      $past(reset) |-> vma == '0 && pc == '0 && heldOrPc == '0)
    else begin
      failCount++;
      $error("FAIL %0t vma pc heldOrPc after reset expected 0 0 0 got %h %h %h", $time,
             $sampled(vma), $sampled(pc), $sampled(heldOrPc));
    end

endmodule

bind vmaBoard vmaBoard_assertions checks (
  .clk         (clk),
  .reset       (reset),
  .ctl         (ctl),
  .ad          (ad),
  .trapMix     (trapMix),
  .vma         (vma),
  .pc          (pc),
  .held        (held),
  .heldOrPc    (heldOrPc),
  .adrBrk      (adrBrk),
  .prevSection (prevSection),
  .flags       (flags),
  .ebusData    (ebusData),
  .ebusDriving (ebusDriving)
);

/* tb/vmaBoardTb.sv */
`timescale 1ns/100ps

module vmaBoardTb import kl10WordPkg::*, vmaCtlPkg::*; ();

  localparam int resetCycles  = 5;
  // 1,600 stimulus cycles plus margin
  localparam int timeoutLimit = 2000;

  logic        clk = 1'b0;
  logic        reset;
  vmaCtlT      ctl;
  kl10Word     ad;
  offsetT      trapMix;
  vmaAddrT     vma;
  vmaAddrT     pc;
  vmaAddrT     heldOrPc;
  vmaFlagsT    flags;
  kl10Word     ebusData;
  logic        ebusDriving;
  logic [31:0] randState = 32'h76057297;
  int          cycleCount = 0;

  vmaBoard UUT (
    .clk         (clk),
    .reset       (reset),
    .ctl         (ctl),
    .ad          (ad),
    .trapMix     (trapMix),
    .vma         (vma),
    .pc          (pc),
    .heldOrPc    (heldOrPc),
    .flags       (flags),
    .ebusData    (ebusData),
    .ebusDriving (ebusDriving)
  );

  always #20 clk = ~clk;

  always @(negedge clk) begin
    cycleCount++;
    if (UUT.checks.failCount != 0) begin
      $display("Testbench failed");
      $fatal(1, "Assertion error reported at %0t", $time);
    end else if (cycleCount >= timeoutLimit) begin
      $display("Testbench failed");
      $fatal(1, "Run did not finish within %0d cycles", timeoutLimit);
    end
  end

  // Upper half of the LCG state since its low bits repeat quickly
  function automatic logic [15:0] rand16();
    randState = randState * 32'd1664525 + 32'd1013904223;
    return randState[31:16];
  endfunction

  function automatic kl10Word randomWord();
    return {4'(rand16()), rand16(), rand16()};
  endfunction

  function automatic vmaCtlT randomCtl();
    vmaCtlT      c;
    logic [31:0] r;
    logic [15:0] s;
    r = {rand16(), rand16()};
    s = rand16();
    c.loadVma         = r[0];
    c.vmaAd           = r[1];
    c.vmaInc          = r[2];
    c.magicEn         = r[3];
    // Zero magic now and then reaches the trap path
    c.magic           = r[13] ? 9'd0 : r[12:4];
    c.vmaxEn          = r[14];
    c.vmaxSel         = vmaxSelT'(r[16:15]);
    c.loadPc          = r[17];
    c.loadHeld        = r[18];
    c.dataoApr        = r[19] & r[20];
    c.loadPrevContext = r[21] & r[22];
    c.condSelVma      = r[23];
    c.extended        = r[24];
    c.fetch           = r[25] & r[26];
    c.memRef          = r[27];
    c.diagRead        = r[28];
    c.diagSel         = diagSelT'(s[2:0] % 3'd5);
    return c;
  endfunction

  task automatic driveCycle(input vmaCtlT c, input kl10Word a, input offsetT t);
    @(posedge clk);
    #2;
    ctl     = c;
    ad      = a;
    trapMix = t;
  endtask

  initial begin
    vmaCtlT  c;
    kl10Word a;
    kl10Word brk;
    reset   = 1'b1;
    ctl     = '0;
    ad      = '0;
    trapMix = '0;
    repeat (resetCycles) @(posedge clk);
    #2;
    reset = 1'b0;

    repeat (800) begin
      driveCycle(randomCtl(), randomWord(), offsetT'({rand16(), rand16()}));
    end

    // Reset again with registers holding random state
    @(posedge clk);
    #2;
    reset = 1'b1;
    repeat (2) @(posedge clk);
    #2;
    reset = 1'b0;

    // Small AD offsets so the VMA lands on the accumulators
    repeat (300) begin
      c         = randomCtl();
      c.loadVma = 1'b1;
      c.vmaAd   = 1'b1;
      c.vmaxEn  = 1'b1;
      c.vmaxSel = adSec;
      c.memRef  = 1'b1;
      a         = randomWord();
      a[17:5]   = '0;
      if (a[35]) begin
        a[22:18] = '0;
      end
      driveCycle(c, a, '0);
    end

    // Break address followed by a VMA load onto it or one word off
    repeat (150) begin
      brk        = randomWord();
      c          = '0;
      c.dataoApr = 1'b1;
      c.diagRead = 1'b1;
      c.diagSel  = diagBrk;
      driveCycle(c, brk, '0);
      c          = '0;
      c.loadVma  = 1'b1;
      c.vmaAd    = 1'b1;
      c.vmaxEn   = 1'b1;
      c.vmaxSel  = adSec;
      c.diagRead = 1'b1;
      c.diagSel  = diagFlags;
      a          = brk;
      a[0]       = brk[0] ^ brk[35];
      driveCycle(c, a, '0);
    end

    // PREV CONTEXT load followed by each VMAX source in turn
    for (int i = 0; i < 100; i++) begin
      c                 = '0;
      c.loadPrevContext = 1'b1;
      driveCycle(c, randomWord(), '0);
      c         = randomCtl();
      c.loadVma = 1'b1;
      c.vmaxEn  = 1'b1;
      c.vmaxSel = vmaxSelT'(i[1:0]);
      driveCycle(c, randomWord(), offsetT'({rand16(), rand16()}));
    end

    repeat (3) @(posedge clk);
    #2;
    if (UUT.checks.failCount == 0) begin
      $display("Testbench passed");
      $finish;
    end else begin
      $display("Testbench failed");
      $fatal(1, "Assertion checks reported errors");
    end
  end

endmodule

/* vmaBoard.f */
hdl/kl10WordPkg.sv
hdl/vmaCtlPkg.sv
hdl/vmaDatapath.sv
hdl/vmaConfigRegs.sv
hdl/vmaDecode.sv
hdl/vmaDiagMux.sv
hdl/vmaBoard.sv
tb/vmaBoard_assertions.sv
tb/vmaBoardTb.sv

/* runSim.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

buildDir=obj_dir
logFile=sim.log

verilator --binary --timing --assert -j 0 \
  --top-module vmaBoardTb -Mdir "$buildDir" -f vmaBoard.f

"./$buildDir/VvmaBoardTb" +verilator+error+limit+1000 > "$logFile" 2>&1 || true
cat "$logFile"

if grep -q "Testbench failed" "$logFile"; then
  exit 1
fi
if ! grep -q "Testbench passed" "$logFile"; then
  echo "Simulation ended without a result"
  exit 1
fi
